// ==== bench/corr_asserts.sv ====
/* Concurrent checks on the correlator top level, bound into corr_top */

`timescale 1ns/1ps

module corr_asserts (
	input logic intclk,
	input logic arst_n,
	input logic word_valid,
	input logic frame_start,
	input logic counts_ready
);

	start_is_valid: assert property (@(posedge intclk) disable iff (!arst_n)
		frame_start |-> word_valid)
		else $error("frame_start seen without word_valid");

	// word_valid is high exactly while the serializer is out of IDLE
	ready_in_idle: assert property (@(posedge intclk) disable iff (!arst_n)
		counts_ready |-> !word_valid)
		else $error("counts_ready arrived while a frame was still being sent");

	quiet_in_reset: assert property (@(posedge intclk) !arst_n |-> !word_valid)
		else $error("word_valid high during reset");

endmodule

bind corr_top corr_asserts u_asserts (
	.intclk       (intclk),
	.arst_n       (arst_n),
	.word_valid   (word_valid),
	.frame_start  (frame_start),
	.counts_ready (counts_ready)
);

// ==== bench/corr_checker.sv ====
/* Reference model of the correlator, frame word comparison
 * and one report line per test */

`timescale 1ns/1ps

module corr_checker (
	input logic intclk,
	input logic arst_n,
	input logic sample_strobe,
	input corr_pkg::lines_t line_in,
	input corr_pkg::lines_t invert_mask,
	input logic word_valid,
	input logic frame_start,
	input corr_pkg::count_t word_out,
	input int test_no,
	output int error_count,
	output int frame_count,
	output int tests_failed
);

	corr_pkg::lines_t hist [corr_pkg::NUM_LAGS]; // hist[0] is the newest sample
	int acc [corr_pkg::NUM_COUNTS];
	corr_pkg::count_t exp_words [$];
	int win_end_cyc [$]; // Cycle of the last strobe of each finished window
	int strobe_cnt;
	int cyc;
	int word_no;
	int frame_idx;
	logic in_frame;
	corr_pkg::frame_no_t next_frame_no;
	int cur_test;
	int test_err_base;
	int test_frame_base;

	function automatic string test_name(input int n);
		case (n)
			1: return "reset_quiet";
			2: return "random_lines";
			3: return "inverted_lines";
			4: return "frame_format";
			5: return "frame_timing";
			default: return "unknown";
		endcase
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		error_count++;
	endtask

	// Model --------------------
	task automatic add_hit(input int n, input logic h);
		if (h && acc[n] < (1 << corr_pkg::COUNT_W) - 1)
			acc[n] = acc[n] + 1; // Saturates at the top of count_t
	endtask

	task automatic take_sample(input corr_pkg::lines_t eff);
		int n;
		for (int k = corr_pkg::NUM_LAGS - 1; k > 0; k--)
			hist[k] = hist[k-1];
		hist[0] = eff;
		n = 0;
		for (int i = 0; i < corr_pkg::NUM_INPUTS; i++) begin
			for (int k = 0; k < corr_pkg::NUM_LAGS; k++) begin
				add_hit(n, eff[i] & hist[k][i]);
				n++;
			end
		end
		for (int a = 0; a < corr_pkg::NUM_INPUTS; a++) begin
			for (int b = a + 1; b < corr_pkg::NUM_INPUTS; b++) begin
				for (int k = 0; k < corr_pkg::NUM_LAGS; k++) begin
					add_hit(n, eff[a] & hist[k][b]);
					n++;
				end
			end
		end
		strobe_cnt++;
		if (strobe_cnt == corr_pkg::WIN_SAMPLES) begin
			for (int j = 0; j < corr_pkg::NUM_COUNTS; j++) begin
				exp_words.push_back(corr_pkg::count_t'(acc[j]));
				acc[j] = 0;
			end
			win_end_cyc.push_back(cyc);
			strobe_cnt = 0;
		end
	endtask

	// Frame comparison --------------------
	task automatic check_word;
		int lat;
		string tn;
		tn = test_name(cur_test);
		if (frame_start) begin
			if (in_frame)
				report_error($sformatf("%s: frame_start after only %0d words of a frame", tn, word_no));
			if (win_end_cyc.size() == 0) begin
				report_error($sformatf("%s: a header came out before any window was complete", tn));
			end else begin
				lat = cyc - win_end_cyc.pop_front();
				if (lat != 3) // Sampler, correlator and serializer each add one cycle
					report_error($sformatf("[ERROR] %s: header latency expected 3 actual %0d", tn, lat));
			end
			if (word_out !== corr_pkg::count_t'(next_frame_no))
				report_error($sformatf("[ERROR] %s: frame header expected 0x%04h actual 0x%04h",
					tn, next_frame_no, word_out));
			frame_idx = int'(next_frame_no);
			next_frame_no++;
			in_frame = 1'b1;
			word_no = 1;
		end else if (!in_frame) begin
			report_error($sformatf("%s: word_valid high outside a frame", tn));
		end else begin
			if (word_no >= corr_pkg::FRAME_WORDS)
				report_error($sformatf("%s: frame %0d runs past its last word", tn, frame_idx));
			else if (exp_words.size() == 0)
				report_error($sformatf("%s: frame %0d has a word with no count expected", tn, frame_idx));
			else if (word_out !== exp_words[0])
				report_error($sformatf("[ERROR] %s: frame %0d word %0d expected 0x%04h actual 0x%04h",
					tn, frame_idx, word_no, exp_words[0], word_out));
			if (word_no < corr_pkg::FRAME_WORDS && exp_words.size() != 0)
				void'(exp_words.pop_front());
			word_no++;
		end
	endtask

	task automatic close_frame;
		if (word_no != corr_pkg::FRAME_WORDS)
			report_error($sformatf("%s: frame %0d ended after %0d words instead of %0d",
				test_name(cur_test), frame_idx, word_no, corr_pkg::FRAME_WORDS));
		in_frame = 1'b0;
		frame_count++;
	endtask

	task automatic report_test;
		int errs;
		errs = error_count - test_err_base;
		$display("test %0d %s: %0d frames, %0d errors, %s", cur_test, test_name(cur_test),
			frame_count - test_frame_base, errs, (errs == 0) ? "passed" : "failed");
		if (errs != 0)
			tests_failed++;
	endtask

	always @(posedge intclk) begin
		if (!arst_n) begin
			for (int k = 0; k < corr_pkg::NUM_LAGS; k++)
				hist[k] = '0;
			for (int n = 0; n < corr_pkg::NUM_COUNTS; n++)
				acc[n] = 0;
			exp_words.delete();
			win_end_cyc.delete();
			strobe_cnt = 0;
			cyc = 0;
			word_no = 0;
			frame_idx = 0;
			in_frame = 1'b0;
			next_frame_no = '0;
			error_count = 0;
			frame_count = 0;
			tests_failed = 0;
			cur_test = 0;
			test_err_base = 0;
			test_frame_base = 0;
		end else begin
			cyc++;
			if (test_no != cur_test) begin
				if (cur_test != 0)
					report_test();
				cur_test = test_no;
				test_err_base = error_count;
				test_frame_base = frame_count;
			end
			if (word_valid)
				check_word();
			else if (in_frame)
				close_frame();
			if (sample_strobe)
				take_sample(line_in ^ invert_mask);
		end
	end

endmodule

// ==== bench/tb_corr.sv ====
/* Testbench for the correlator: clock, reset, LFSR stimulus,
 * the checker and the run summary */

`timescale 1ns/1ps

module tb_corr;

	logic intclk = 1'b0;
	logic arst_n;
	logic sample_strobe;
	corr_pkg::lines_t line_in;
	corr_pkg::lines_t invert_mask;
	logic word_valid;
	logic frame_start;
	corr_pkg::count_t word_out;

	int test_no;
	int error_count;
	int frame_count;
	int tests_failed;
	int total_strobes;
	int mask_pick; // Strobe count at which invert_mask was last chosen
	logic [31:0] lfsr = 32'h62358fcb;

	always #2 intclk = ~intclk; // 4 ns period

	corr_top UUT (
		.intclk        (intclk),
		.arst_n        (arst_n),
		.sample_strobe (sample_strobe),
		.line_in       (line_in),
		.invert_mask   (invert_mask),
		.word_valid    (word_valid),
		.frame_start   (frame_start),
		.word_out      (word_out)
	);

	corr_checker u_checker (
		.intclk        (intclk),
		.arst_n        (arst_n),
		.sample_strobe (sample_strobe),
		.line_in       (line_in),
		.invert_mask   (invert_mask),
		.word_valid    (word_valid),
		.frame_start   (frame_start),
		.word_out      (word_out),
		.test_no       (test_no),
		.error_count   (error_count),
		.frame_count   (frame_count),
		.tests_failed  (tests_failed)
	);

	// Stimulus --------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// A cycle strobes when strobe_bits random bits are all one
	task automatic drive_strobes(input int n, input int strobe_bits, input logic new_masks);
		int given;
		int cycles;
		logic [31:0] r;
		given = 0;
		cycles = 0;
		while (given < n && cycles < n * 64) begin
			@(negedge intclk);
			cycles++;
			if (new_masks && total_strobes % corr_pkg::WIN_SAMPLES == 0
					&& mask_pick != total_strobes) begin
				rand_bits(corr_pkg::NUM_INPUTS, r);
				invert_mask = r[3:0];
				mask_pick = total_strobes;
			end
			rand_bits(strobe_bits, r);
			sample_strobe = (r == ((32'd1 << strobe_bits) - 32'd1));
			rand_bits(corr_pkg::NUM_INPUTS, r);
			line_in = r[3:0];
			if (sample_strobe) begin
				given++;
				total_strobes++;
			end
		end
		@(negedge intclk);
		sample_strobe = 1'b0;
		if (given < n) begin
			$display("Stimulus stalled after %0d of %0d strobes", given, n);
			$display("Test FAILED");
			$finish;
		end
	endtask

	task automatic wait_frames(input int target);
		int cycles;
		cycles = 0;
		while (frame_count < target && cycles < 500) begin
			@(negedge intclk);
			cycles++;
		end
		if (frame_count < target) begin
			$display("Timeout: frame %0d did not finish within 500 cycles", target - 1);
			$display("Test FAILED");
			$finish;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge intclk);
	endtask

	initial begin
		arst_n = 1'b0;
		sample_strobe = 1'b0;
		line_in = '0;
		invert_mask = '0;
		test_no = 1;
		total_strobes = 0;
		mask_pick = -1;
		repeat (5) @(posedge intclk);
		@(negedge intclk);
		arst_n = 1'b1;

		// One strobe short of a window, then a pause with no output expected
		drive_strobes(corr_pkg::WIN_SAMPLES - 1, 1, 1'b0);
		idle_cycles(20);
		drive_strobes(1, 1, 1'b0);
		wait_frames(1);

		test_no = 2;
		drive_strobes(3 * corr_pkg::WIN_SAMPLES, 1, 1'b0);
		wait_frames(4);

		test_no = 3;
		drive_strobes(3 * corr_pkg::WIN_SAMPLES, 1, 1'b1);
		wait_frames(7);

		test_no = 4; // A strobe on every cycle so frames come close together
		drive_strobes(4 * corr_pkg::WIN_SAMPLES, 0, 1'b1);
		wait_frames(11);

		test_no = 5;
		drive_strobes(3 * corr_pkg::WIN_SAMPLES, 2, 1'b1);
		wait_frames(14);

		test_no = 6; // Lets the checker close the last test
		idle_cycles(3);
		$display("5 tests, %0d failed, %0d frames, %0d errors",
			tests_failed, frame_count, error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
src/corr_pkg.sv
src/line_sampler.sv
src/lag_correlator.sv
src/frame_serializer.sv
src/corr_top.sv
bench/corr_checker.sv
bench/corr_asserts.sv
bench/tb_corr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the correlator testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module tb_corr -Mdir obj_dir -o tb_corr
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_corr > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	echo "Failure reported in $LOG"
	exit 1
fi
exit 0

// ==== src/corr_pkg.sv ====
/* Correlator sizes, vector types, the sampler and count-set structs
 * and the serializer state encoding */

package corr_pkg;

	// Sizes --------------------
	localparam int NUM_INPUTS = 4;
	localparam int NUM_LAGS = 4; // Lags 0 to NUM_LAGS-1
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int WIN_SAMPLES = 64; // Strobes per integration window
	localparam int AUTO_COUNTS = NUM_INPUTS * NUM_LAGS;
	localparam int NUM_COUNTS = AUTO_COUNTS + NUM_BASELINES * NUM_LAGS;
	localparam int FRAME_WORDS = NUM_COUNTS + 1; // Header plus counts

	localparam int COUNT_W = 16;
	localparam int WIN_CNT_W = $clog2(WIN_SAMPLES);
	localparam int WORD_IDX_W = $clog2(FRAME_WORDS);

	// Vector types --------------------
	typedef logic [NUM_INPUTS-1:0] lines_t;
	typedef logic [COUNT_W-1:0] count_t; // Also the width of a frame word
	typedef logic [WIN_CNT_W-1:0] win_cnt_t;
	typedef logic [15:0] frame_no_t;
	typedef logic [WORD_IDX_W-1:0] word_idx_t;

	// The sampler feeds the correlator with hist[0] as the current sample and hist[k] k strobes old
	typedef struct packed {
		logic strobe;
		logic window_end;
		lines_t cur;
		lines_t [NUM_LAGS-1:0] hist;
	} sample_bus_t;

	// Entry 0 is the first count word of a frame
	typedef count_t [NUM_COUNTS-1:0] count_set_t;

	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		COUNTS
	} ser_state_t;

endpackage

// ==== src/corr_top.sv ====
/* Top level of the one-bit correlator: sampler, correlator and serializer */

`timescale 1ns/1ps

module corr_top (
	input logic intclk,
	input logic arst_n,
	input logic sample_strobe,
	input corr_pkg::lines_t line_in,
	input corr_pkg::lines_t invert_mask,
	output logic word_valid,
	output logic frame_start,
	output corr_pkg::count_t word_out
);

	corr_pkg::sample_bus_t sample_bus;
	logic counts_ready; // One cycle wide, once per window
	corr_pkg::count_set_t count_set;

	line_sampler u_sampler (
		.intclk        (intclk),
		.arst_n        (arst_n),
		.sample_strobe (sample_strobe),
		.line_in       (line_in),
		.invert_mask   (invert_mask),
		.sample_bus    (sample_bus)
	);

	lag_correlator u_correlator (
		.intclk       (intclk),
		.arst_n       (arst_n),
		.sample_bus   (sample_bus),
		.counts_ready (counts_ready),
		.count_set    (count_set)
	);

	frame_serializer u_serializer (
		.intclk       (intclk),
		.arst_n       (arst_n),
		.counts_ready (counts_ready),
		.count_set    (count_set),
		.word_valid   (word_valid),
		.frame_start  (frame_start),
		.word_out     (word_out)
	);

endmodule

// ==== src/frame_serializer.sv ====
/* Output side: frame numbering and the strobed word stream
 * of header plus captured counts */

`timescale 1ns/1ps

module frame_serializer (
	input logic intclk,
	input logic arst_n,
	input logic counts_ready,
	input corr_pkg::count_set_t count_set,
	output logic word_valid,
	output logic frame_start,
	output corr_pkg::count_t word_out
);

	corr_pkg::ser_state_t state;
	corr_pkg::word_idx_t word_idx;
	corr_pkg::frame_no_t frame_no;
	corr_pkg::count_set_t copy;
	logic last_word;

	assign last_word = (word_idx == corr_pkg::word_idx_t'(corr_pkg::NUM_COUNTS - 1));

	// Control FSM --------------------
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= corr_pkg::IDLE;
			word_idx <= '0;
			frame_no <= '0;
		end else begin
			case (state)
				corr_pkg::IDLE: begin
					word_idx <= '0;
					if (counts_ready)
						state <= corr_pkg::HEADER;
				end
				corr_pkg::HEADER: begin
					state <= corr_pkg::COUNTS;
				end
				corr_pkg::COUNTS: begin
					if (last_word) begin
						state <= corr_pkg::IDLE;
						frame_no <= frame_no + corr_pkg::frame_no_t'(1);
					end else begin
						word_idx <= word_idx + corr_pkg::word_idx_t'(1);
					end
				end
				default: state <= corr_pkg::IDLE;
			endcase
		end
	end

	// Own copy so the correlator may capture again while a frame is out
	always_ff @(posedge intclk) begin
		if (state == corr_pkg::IDLE && counts_ready)
			copy <= count_set;
	end

	// Output words --------------------
	always_comb begin
		word_valid = (state != corr_pkg::IDLE);
		frame_start = (state == corr_pkg::HEADER);
		case (state)
			corr_pkg::HEADER: word_out = corr_pkg::count_t'(frame_no);
			corr_pkg::COUNTS: word_out = copy[word_idx];
			default: word_out = '0;
		endcase
	end

endmodule

// ==== src/lag_correlator.sv ====
/* Processing: auto and cross coincidence counters per lag,
 * with capture and clear at the end of each window */

`timescale 1ns/1ps

module lag_correlator (
	input logic intclk,
	input logic arst_n,
	input corr_pkg::sample_bus_t sample_bus,
	output logic counts_ready,
	output corr_pkg::count_set_t count_set
);

	logic [corr_pkg::NUM_COUNTS-1:0] hit;
	corr_pkg::count_set_t acc;
	corr_pkg::count_set_t acc_next;

	// Holds at the top of the range instead of wrapping
	function automatic corr_pkg::count_t sat_inc(input corr_pkg::count_t c, input logic h);
		corr_pkg::count_t r;
		r = c;
		if (h && (c != '1))
			r = c + corr_pkg::count_t'(1);
		return r;
	endfunction

	// Coincidence detection --------------------
	always_comb begin
		int base;
		hit = '0;
		// Auto terms go line major and lag minor
		for (int i = 0; i < corr_pkg::NUM_INPUTS; i++) begin
			for (int k = 0; k < corr_pkg::NUM_LAGS; k++)
				hit[i*corr_pkg::NUM_LAGS + k] = sample_bus.cur[i] & sample_bus.hist[k][i];
		end
		// Cross terms follow in pair order (0,1), (0,2) ... (2,3)
		base = corr_pkg::AUTO_COUNTS;
		for (int a = 0; a < corr_pkg::NUM_INPUTS; a++) begin
			for (int b = a + 1; b < corr_pkg::NUM_INPUTS; b++) begin
				for (int k = 0; k < corr_pkg::NUM_LAGS; k++)
					hit[base + k] = sample_bus.cur[a] & sample_bus.hist[k][b];
				base = base + corr_pkg::NUM_LAGS;
			end
		end
	end

	always_comb begin
		for (int n = 0; n < corr_pkg::NUM_COUNTS; n++)
			acc_next[n] = sat_inc(acc[n], hit[n]);
	end

	// Accumulators --------------------
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
			counts_ready <= 1'b0;
		end else begin
			counts_ready <= sample_bus.strobe && sample_bus.window_end;
			if (sample_bus.strobe) begin
				if (sample_bus.window_end)
					acc <= '0; // Next window starts from zero
				else
					acc <= acc_next;
			end
		end
	end

	// The final sample of the window is folded in while capturing
	always_ff @(posedge intclk) begin
		if (sample_bus.strobe && sample_bus.window_end)
			count_set <= acc_next;
	end

endmodule

// ==== src/line_sampler.sv ====
/* Input side: polarity inversion, per-line sample history
 * and integration window counting */

`timescale 1ns/1ps

module line_sampler (
	input logic intclk,
	input logic arst_n,
	input logic sample_strobe,
	input corr_pkg::lines_t line_in,
	input corr_pkg::lines_t invert_mask,
	output corr_pkg::sample_bus_t sample_bus
);

	corr_pkg::lines_t eff;
	corr_pkg::win_cnt_t win_cnt;
	logic last_in_win;

	assign eff = line_in ^ invert_mask; // Selected lines are inverted
	assign last_in_win = (win_cnt == corr_pkg::win_cnt_t'(corr_pkg::WIN_SAMPLES - 1));

	// Window counter --------------------
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			win_cnt <= '0;
		end else if (sample_strobe) begin
			if (last_in_win)
				win_cnt <= '0;
			else
				win_cnt <= win_cnt + corr_pkg::win_cnt_t'(1);
		end
	end

	// Sample bus and history --------------------
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			sample_bus <= '0;
		end else begin
			sample_bus.strobe <= sample_strobe;
			sample_bus.window_end <= sample_strobe && last_in_win;
			if (sample_strobe) begin
				sample_bus.cur <= eff;
				sample_bus.hist[0] <= eff;
				for (int k = 1; k < corr_pkg::NUM_LAGS; k++)
					sample_bus.hist[k] <= sample_bus.hist[k-1]; // Older samples move down one slot
			end
		end
	end

endmodule
